/* src/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// ##############################
// Decoder limits
// ##############################

`define DEC_WINDOW_BYTES 16     // Instruction bytes held per decode
`define DEC_MAX_LEN      15     // Longest legal x86 instruction
`define DEC_MAX_PREFIX   3      // Legacy prefixes allowed before flagging

// ##############################
// Register map, byte offsets
// ##############################

`define DEC_REG_CTRL   8'h00    // Bit 0 start, write only
`define DEC_REG_STATUS 8'h04    // busy, done, unsupported, too_long
`define DEC_REG_RESULT 8'h08    // Packed decode result
`define DEC_REG_WIN0   8'h10    // First of four window words

`endif

/* src/decode_pkg.sv */
package decode_pkg;

    // ##############################
    // Enumerations
    // ##############################

    typedef enum logic [2:0] {
        IDLE,
        SCAN,       // Prefix marks captured
        LOCATE,     // Opcode position captured
        MEASURE,    // Length captured
        DONE
    } dec_state_e;

    typedef enum logic [1:0] {
        NONE,       // No immediate
        IMM8,
        IMM16_32,   // 16 bits under 66 prefix
        BAD         // Opcode outside the table
    } imm_kind_e;

    // ##############################
    // Structures between blocks
    // ##############################

    // Byte 0 sits in the low eight bits
    typedef logic [15:0][7:0] insn_window_t;

    typedef struct packed {
        logic [4:0] is_opcode;      // Bytes 0-4 that are not prefixes
        logic [2:0] count;          // Leading prefixes
        logic       opsize;         // 66 among the leading prefixes
        logic       too_many;       // Beyond the prefix limit
    } prefix_info_t;

    typedef struct packed {
        logic [2:0] opcode_sel;     // Bit 2 escape, bits 1-0 byte index
        logic       opcode_size;    // Set for two-byte opcodes
    } opcode_pos_t;

    typedef struct packed {
        logic [3:0] length;
        logic [2:0] prefix_count;
        logic [2:0] opcode_sel;
        logic       has_modrm;
        imm_kind_e  imm;
        logic       unsupported;
        logic       too_long;
    } decode_result_t;

endpackage

/* src/axil_regs.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module axil_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [7:0]                 awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [7:0]                 araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    output logic                       start,
    output decode_pkg::insn_window_t   window,
    input  logic                       busy,
    input  logic                       done,
    input  decode_pkg::decode_result_t result
);
    import decode_pkg::*;

    insn_window_t win_q;
    logic         aw_done, w_done;      // Channel already accepted
    logic [7:0]   awaddr_q;
    logic [31:0]  wdata_q;
    logic [3:0]   wstrb_q;
    logic         aw_hs, w_hs, ar_hs;
    logic         wr_fire;
    logic [7:0]   wr_addr;
    logic [31:0]  wr_data;
    logic [3:0]   wr_strb;
    logic [31:0]  status_word, result_word;

    // ##############################
    // Write channels
    // ##############################

    assign awready = !aw_done && !bvalid;  // Stalls while response pending
    assign wready  = !w_done && !bvalid;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
    assign wr_addr = aw_done ? awaddr_q : awaddr;
    assign wr_data = w_done ? wdata_q : wdata;
    assign wr_strb = w_done ? wstrb_q : wstrb;
    assign bresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
        end else begin
            start <= wr_fire && (wr_addr == `DEC_REG_CTRL) && wr_strb[0] && wr_data[0];
            if (wr_fire) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (aw_hs)
                    aw_done <= 1'b1;
                if (w_hs)
                    w_done <= 1'b1;
                if (bvalid && bready)
                    bvalid <= 1'b0;
            end
        end
    end

    // Whichever channel arrives first waits here
    always_ff @(posedge clk) begin
        if (aw_hs)
            awaddr_q <= awaddr;
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire && (wr_addr >= `DEC_REG_WIN0) &&
            (wr_addr < `DEC_REG_WIN0 + `DEC_WINDOW_BYTES)) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b])
                    win_q[{wr_addr[3:2], 2'(b)}] <= wr_data[8*b +: 8];  // Little-endian
            end
        end
    end

    assign window = win_q;

    // ##############################
    // Read channels
    // ##############################

    assign arready = !rvalid;               // One read outstanding
    assign ar_hs   = arvalid && arready;
    assign rresp   = 2'b00;

    assign status_word = {28'd0, result.too_long, result.unsupported, done, busy};
    assign result_word = {14'd0, result.imm, 3'd0, result.has_modrm, 1'b0,
                          result.opcode_sel, 1'b0, result.prefix_count, result.length};

    always_ff @(posedge clk) begin
        if (reset)
            rvalid <= 1'b0;
        else if (ar_hs)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (araddr)
                `DEC_REG_STATUS: rdata <= status_word;
                `DEC_REG_RESULT: rdata <= result_word;
                default:         rdata <= 32'd0;  // Window and CTRL not readable
            endcase
        end
    end

endmodule

/* src/decode_ctrl.sv */
`timescale 1ns/1ns

module decode_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  decode_pkg::insn_window_t   window,
    output logic                       busy,
    output logic                       done,
    output decode_pkg::decode_result_t result,
    output decode_pkg::insn_window_t   snap_window,
    input  decode_pkg::prefix_info_t   prefix_in,
    output decode_pkg::prefix_info_t   prefix_reg,
    input  decode_pkg::opcode_pos_t    pos_in,
    output decode_pkg::opcode_pos_t    pos_reg,
    input  decode_pkg::decode_result_t result_in
);
    import decode_pkg::*;

    dec_state_e state;
    logic       launch;

    assign busy   = (state == SCAN) || (state == LOCATE) || (state == MEASURE);
    assign launch = start && !busy;        // Start during a decode is dropped

    // ##############################
    // Sequencer
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            done   <= 1'b0;
            result <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (launch) begin
                        state <= SCAN;
                        done  <= 1'b0;      // Cleared only by a new start
                    end else begin
                        state <= IDLE;
                    end
                end
                SCAN:    state <= LOCATE;
                LOCATE:  state <= MEASURE;
                MEASURE: begin
                    state  <= DONE;
                    done   <= 1'b1;
                    result <= result_in;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ##############################
    // Stage registers
    // ##############################

    always_ff @(posedge clk) begin
        if (launch)
            snap_window <= window;          // Host may rewrite the window now
        if (state == SCAN)
            prefix_reg <= prefix_in;
        if (state == LOCATE)
            pos_reg <= pos_in;
    end

endmodule

/* src/prefix_scan.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module prefix_scan (
    input  decode_pkg::insn_window_t window,
    output decode_pkg::prefix_info_t info
);
    import decode_pkg::*;

    prefix_info_t scan;
    logic [4:0]   is_pfx;

    // Legacy prefix set
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            case (window[i])
                8'hF0, 8'hF2, 8'hF3,                    // Lock and repeat
                8'h2E, 8'h36, 8'h3E, 8'h26,
                8'h64, 8'h65,                           // Segment overrides
                8'h66, 8'h67: is_pfx[i] = 1'b1;         // Size overrides
                default:      is_pfx[i] = 1'b0;
            endcase
        end
    end

    always_comb begin
        logic lead;

        lead           = 1'b1;
        scan.is_opcode = ~is_pfx;
        scan.count     = 3'd0;
        scan.opsize    = 1'b0;
        for (int i = 0; i < 5; i++) begin
            lead = lead && is_pfx[i];           // Still inside the prefix run
            if (lead) begin
                scan.count = scan.count + 3'd1;
                if (window[i] == 8'h66)
                    scan.opsize = 1'b1;
            end
        end
        scan.too_many = (scan.count > `DEC_MAX_PREFIX);
    end

    assign info = scan;

endmodule

/* src/opcode_locator.sv */
`timescale 1ns/1ns

module opcode_locator (
    input  decode_pkg::insn_window_t window,
    input  decode_pkg::prefix_info_t info,
    output decode_pkg::opcode_pos_t  pos
);
    import decode_pkg::*;

    opcode_pos_t loc;
    logic [1:0]  idx;
    logic [2:0]  nxt;
    logic        esc;

    // First non-prefix byte among bytes 0-3
    always_comb begin
        if (info.is_opcode[0])
            idx = 2'd0;
        else if (info.is_opcode[1])
            idx = 2'd1;
        else if (info.is_opcode[2])
            idx = 2'd2;
        else if (info.is_opcode[3])
            idx = 2'd3;
        else
            idx = 2'd0;                         // Prefix run too long anyway
    end

    assign nxt = {1'b0, idx} + 3'd1;

    // 0F escape counts only when the next byte is not a prefix
    assign esc = (window[idx] == 8'h0F) && info.is_opcode[nxt];

    always_comb begin
        loc.opcode_sel  = {esc, idx};
        loc.opcode_size = esc;
    end

    assign pos = loc;

endmodule

/* src/length_calc.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module length_calc (
    input  decode_pkg::insn_window_t   window,
    input  decode_pkg::prefix_info_t   info,
    input  decode_pkg::opcode_pos_t    pos,
    output decode_pkg::decode_result_t result
);
    import decode_pkg::*;

    logic [2:0] opc_i;
    logic [7:0] opc, modrm, sib;
    logic       has_modrm, has_sib;
    imm_kind_e  kind;
    logic [2:0] disp_bytes, imm_bytes;
    logic [4:0] sum;
    logic       too_long, unsupported;

    assign opc_i = {1'b0, pos.opcode_sel[1:0]} + {2'b00, pos.opcode_size};
    assign opc   = window[opc_i];
    assign modrm = window[opc_i + 3'd1];
    assign sib   = window[opc_i + 3'd2];

    // ##############################
    // Opcode table subset
    // ##############################

    always_comb begin
        has_modrm = 1'b0;
        kind      = NONE;
        if (pos.opcode_size) begin
            if (opc[7:4] == 4'h8)
                kind = IMM16_32;                // Jcc rel32
            else if (opc == 8'hAF)
                has_modrm = 1'b1;               // IMUL r, r/m
            else
                kind = BAD;
        end else if (opc[7:6] == 2'b00) begin
            case (opc[2:0])                     // ALU group
                3'd0, 3'd1, 3'd2, 3'd3: has_modrm = 1'b1;
                3'd4:    kind = IMM8;
                3'd5:    kind = IMM16_32;
                default: kind = BAD;
            endcase
        end else begin
            case (opc) inside
                [8'h50:8'h5F], 8'h90, 8'hC3: kind = NONE;
                [8'h70:8'h7F], [8'hB0:8'hB7], 8'hEB: kind = IMM8;
                [8'h88:8'h8B]: has_modrm = 1'b1;
                [8'hB8:8'hBF], 8'hE8, 8'hE9: kind = IMM16_32;
                default: kind = BAD;
            endcase
        end
    end

    // ##############################
    // ModRM, SIB and length
    // ##############################

    always_comb begin
        has_sib    = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'd4);
        disp_bytes = 3'd0;
        if (has_modrm) begin
            case (modrm[7:6])
                2'b01: disp_bytes = 3'd1;
                2'b10: disp_bytes = 3'd4;
                2'b00: begin
                    if (modrm[2:0] == 3'd5 || (has_sib && sib[2:0] == 3'd5))
                        disp_bytes = 3'd4;      // Absolute disp32
                end
                default: disp_bytes = 3'd0;     // Register form
            endcase
        end
        case (kind)
            IMM8:     imm_bytes = 3'd1;
            IMM16_32: imm_bytes = info.opsize ? 3'd2 : 3'd4;
            default:  imm_bytes = 3'd0;
        endcase
    end

    assign sum = {2'b00, info.count} + 5'd1 + {4'd0, pos.opcode_size} + {4'd0, has_modrm}
               + {4'd0, has_sib} + {2'b00, disp_bytes} + {2'b00, imm_bytes};
    assign unsupported = (kind == BAD);
    assign too_long    = info.too_many || (sum > `DEC_MAX_LEN);

    always_comb begin
        result.length       = (unsupported || too_long) ? 4'd0 : sum[3:0];
        result.prefix_count = info.count;
        result.opcode_sel   = pos.opcode_sel;
        result.has_modrm    = has_modrm;
        result.imm          = kind;
        result.unsupported  = unsupported;
        result.too_long     = too_long;
    end

endmodule

/* src/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [7:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);
    import decode_pkg::*;

    logic           start, busy, done;
    insn_window_t   window, snap_window;
    prefix_info_t   prefix_in, prefix_reg;
    opcode_pos_t    pos_in, pos_reg;
    decode_result_t result_in, result;

    axil_regs u_regs (.*);                  // Register port

    decode_ctrl u_ctrl (.*);                // Sequencer and stage registers

    prefix_scan u_scan (.window(snap_window), .info(prefix_in));

    opcode_locator u_locate (.window(snap_window), .info(prefix_reg), .pos(pos_in));

    length_calc u_len (.window(snap_window), .info(prefix_reg), .pos(pos_reg),
                       .result(result_in));

endmodule

/* tb/decode_unit_assert.sv */
`timescale 1ns/1ns

module decode_unit_assert (
    input logic        clk,
    input logic        reset,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        start,
    input logic        busy,
    input logic        done
);

    // ##############################
    // Bus responses
    // ##############################

    bresp_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rresp_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read response changed before rready");

    // ##############################
    // Decode sequencing
    // ##############################

    done_after_busy: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> $past(busy))
        else $error("done rose without a decode in progress");

    busy_from_start: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start pulse");

endmodule

bind decode_unit decode_unit_assert u_assert (.*);

/* tb/decode_unit_tb.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_unit_tb;

    localparam int LIMIT = 100;             // Cycles allowed for any wait

    logic        clk, reset;
    logic [7:0]  awaddr, araddr;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [1:0]  bresp, rresp;
    logic [31:0] rdata;

    integer      seed;
    int          errors, checks, tests;
    int          stall_max;                 // Longest bready or rready hold-off
    logic [7:0]  win [16];                  // Window as the host loads it

    decode_unit uut (.*);

    always #10 clk = ~clk;

    // ##############################
    // Checking helpers
    // ##############################

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %0t ns %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s did not arrive within %0d cycles", what, LIMIT);
        errors++;
    endtask

    task automatic report_test(input string name, input int first);
        tests++;
        $display("test %-10s %s", name, (errors == first) ? "ok" : "failed");
    endtask

    // ##############################
    // AXI4-Lite host
    // ##############################

    task automatic send_aw(input logic [7:0] addr);
        int t;
        t = 0;
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!awready)
            timed_out("awready");
        @(negedge clk);                     // Accepted on the edge just passed
        awvalid = 1'b0;
    endtask

    task automatic send_w(input logic [31:0] data);
        int t;
        t = 0;
        wdata  = data;
        wstrb  = 4'hF;
        wvalid = 1'b1;
        while (!wready && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!wready)
            timed_out("wready");
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    // Order 0 sends both together, 1 address first, 2 data first
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data, input int order);
        int t, hold;
        if (order == 1) begin
            send_aw(addr);
            send_w(data);
        end else if (order == 2) begin
            send_w(data);
            send_aw(addr);
        end else begin
            fork
                send_aw(addr);
                send_w(data);
            join
        end
        hold = $unsigned($random(seed)) % (stall_max + 1);
        for (int i = 0; i < hold; i++) begin
            check_value("bvalid", bvalid, 1'b1);
            check_value("awready", awready, 1'b0);  // No new address while held
            check_value("wready", wready, 1'b0);
            @(negedge clk);
        end
        t = 0;
        bready = 1'b1;
        while (!bvalid && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!bvalid)
            timed_out("bvalid");
        else
            check_value("bresp", bresp, 2'b00);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        int t, hold;
        t = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!arready)
            timed_out("arready");
        @(negedge clk);
        arvalid = 1'b0;
        hold = $unsigned($random(seed)) % (stall_max + 1);
        for (int i = 0; i < hold; i++) begin
            check_value("rvalid", rvalid, 1'b1);
            check_value("arready", arready, 1'b0);
            @(negedge clk);
        end
        t = 0;
        rready = 1'b1;
        while (!rvalid && t < LIMIT) begin
            @(negedge clk);
            t++;
        end
        if (!rvalid)
            timed_out("rvalid");
        else
            check_value("rresp", rresp, 2'b00);
        data = rdata;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // ##############################
    // Expected decode
    // ##############################

    function automatic bit is_prefix(input logic [7:0] b);
        return b inside {8'hF0, 8'hF2, 8'hF3, 8'h2E, 8'h36, 8'h3E, 8'h26,
                         8'h64, 8'h65, 8'h66, 8'h67};
    endfunction

    // flags comes back as {too_long, unsupported}
    function automatic logic [31:0] expected_result(output logic [1:0] flags);
        int         p, op, len, disp, imm;
        bit         two, modrm, sib, opsz;
        logic [1:0] kind;                   // 0 none, 1 imm8, 2 imm16/32, 3 unsupported
        logic [7:0] b, m;
        p    = 0;
        opsz = 1'b0;
        while (p < 5 && is_prefix(win[p])) begin
            opsz = opsz || (win[p] == 8'h66);
            p++;
        end
        if (p > 3) begin
            flags = 2'b10;
            return {25'd0, 3'(p), 4'd0};
        end
        two   = (win[p] == 8'h0F) && !is_prefix(win[p + 1]);
        op    = p + int'(two);
        b     = win[op];
        m     = win[op + 1];
        modrm = 1'b0;
        kind  = 2'd3;
        if (two) begin
            if (b[7:4] == 4'h8)
                kind = 2'd2;
            else if (b == 8'hAF) begin
                modrm = 1'b1;
                kind  = 2'd0;
            end
        end else if (b < 8'h40) begin
            if (b[2:0] <= 3'd3) begin
                modrm = 1'b1;
                kind  = 2'd0;
            end else if (b[2:0] == 3'd4)
                kind = 2'd1;
            else if (b[2:0] == 3'd5)
                kind = 2'd2;
        end else if ((b >= 8'h50 && b <= 8'h5F) || b == 8'h90 || b == 8'hC3)
            kind = 2'd0;
        else if ((b >= 8'h70 && b <= 8'h7F) || (b >= 8'hB0 && b <= 8'hB7) || b == 8'hEB)
            kind = 2'd1;
        else if (b >= 8'h88 && b <= 8'h8B) begin
            modrm = 1'b1;
            kind  = 2'd0;
        end else if (b >= 8'hB8 || b == 8'hE8 || b == 8'hE9)
            kind = (b <= 8'hBF || b == 8'hE8 || b == 8'hE9) ? 2'd2 : 2'd3;
        sib  = modrm && m[7:6] != 2'b11 && m[2:0] == 3'd4;
        disp = 0;
        if (modrm && m[7:6] == 2'b01)
            disp = 1;
        else if (modrm && m[7:6] == 2'b10)
            disp = 4;
        else if (modrm && m[7:6] == 2'b00 && (m[2:0] == 3'd5 || (sib && win[op + 2][2:0] == 3'd5)))
            disp = 4;                       // Absolute or SIB without base
        imm   = (kind == 2'd1) ? 1 : (kind == 2'd2) ? (opsz ? 2 : 4) : 0;
        len   = p + 1 + int'(two) + int'(modrm) + int'(sib) + disp + imm;
        flags = {len > 15, kind == 2'd3};
        if (flags != 2'b00)
            len = 0;
        return {14'd0, kind, 3'd0, modrm, 1'b0, two, 2'(p), 1'b0, 3'(p), 4'(len)};
    endfunction

    // ##############################
    // Decode runs
    // ##############################

    task automatic run_decode(input bit twice, output logic [31:0] status,
                              output logic [31:0] result);
        int t;
        for (int i = 0; i < 4; i++)
            axil_write(`DEC_REG_WIN0 + 8'(4 * i),
                       {win[4 * i + 3], win[4 * i + 2], win[4 * i + 1], win[4 * i]}, i % 3);
        axil_write(`DEC_REG_CTRL, 32'd1, 0);
        if (twice) begin
            axil_write(`DEC_REG_CTRL, 32'd1, 0);        // Lands while busy
            axil_write(`DEC_REG_WIN0, 32'hF4F4F4F4, 0); // Decode works on its snapshot
        end
        t = 0;
        axil_read(`DEC_REG_STATUS, status);
        while (!status[1] && t < LIMIT) begin
            axil_read(`DEC_REG_STATUS, status);
            t++;
        end
        if (!status[1])
            timed_out("done in STATUS");
        axil_read(`DEC_REG_RESULT, result);
    endtask

    // Instruction bytes first byte leftmost, random filler after them
    task automatic check_insn(input logic [119:0] code, input int n, input int exp_len,
                              input bit twice);
        logic [31:0] status, result, exp;
        logic [1:0]  flags;
        for (int i = 0; i < 16; i++)
            win[i] = (i < n) ? code[8 * (n - 1 - i) +: 8] : 8'($random(seed));
        exp = expected_result(flags);
        run_decode(twice, status, result);
        check_value("length", result[3:0], exp_len);
        if (flags[1]) begin
            check_value("result", result & 32'h7F, exp & 32'h7F);
            check_value("status", status & 32'hB, {28'd0, 4'b1010});
        end else begin
            check_value("result", result, exp);
            check_value("status", status, {28'd0, flags, 2'b10});
        end
    endtask

    // ##############################
    // Directed tests
    // ##############################

    task automatic test_reset();
        int          first;
        logic [31:0] data;
        first = errors;
        check_value("ready_valid", {awready, arready, bvalid, rvalid}, 4'b1100);
        axil_read(`DEC_REG_STATUS, data);
        check_value("status", data, 32'd0);
        axil_write(`DEC_REG_CTRL, 32'd0, 1);
        axil_write(`DEC_REG_CTRL, 32'd0, 2);
        axil_read(`DEC_REG_STATUS, data);
        check_value("status", data, 32'd0);
        axil_read(`DEC_REG_RESULT, data);
        check_value("result", data, 32'd0);
        report_test("reset", first);
    endtask

    task automatic test_one_byte();
        int first;
        first = errors;
        check_insn(120'h90, 1, 1, 0);
        check_insn(120'hB8_78563412, 5, 5, 0);
        check_insn(120'h04_7F, 2, 2, 0);
        check_insn(120'hE8_00010000, 5, 5, 0);
        report_test("one_byte", first);
    endtask

    task automatic test_prefix();
        int first;
        first = errors;
        check_insn(120'h66_B8_3412, 4, 4, 0);
        check_insn(120'hF0_2E_0F_85_10000000, 8, 8, 0);
        check_insn(120'h0F_AF_C3, 3, 3, 0);
        report_test("prefix", first);
    endtask

    task automatic test_modrm();
        int first;
        first = errors;
        check_insn(120'h8B_C0, 2, 2, 0);            // Register form
        check_insn(120'h8B_45_08, 3, 3, 0);
        check_insn(120'h8B_85_00100000, 6, 6, 0);
        check_insn(120'h8B_04_24, 3, 3, 0);
        check_insn(120'h8B_04_25_00200000, 7, 7, 0);
        report_test("modrm", first);
    endtask

    task automatic test_errors();
        int first;
        first = errors;
        check_insn(120'hF4, 1, 0, 0);
        check_insn(120'h66_67_F3_2E_90, 5, 0, 0);   // One prefix too many
        report_test("errors", first);
    endtask

    task automatic test_backpressure();
        int first;
        first = errors;
        stall_max = 6;
        check_insn(120'h8B_85_00100000, 6, 6, 0);
        check_insn(120'hF0_2E_0F_85_10000000, 8, 8, 0);
        stall_max = 0;
        check_insn(120'hB8_44332211, 5, 5, 1);
        report_test("busy", first);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        awaddr    = 8'd0;
        awvalid   = 1'b0;
        wdata     = 32'd0;
        wstrb     = 4'h0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = 8'd0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        seed      = 84170;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        stall_max = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset();
        test_one_byte();
        test_prefix();
        test_modrm();
        test_errors();
        test_backpressure();
        $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* decode_unit.f */
+incdir+src
src/decode_pkg.sv
src/axil_regs.sv
src/decode_ctrl.sv
src/prefix_scan.sv
src/opcode_locator.sv
src/length_calc.sv
src/decode_unit.sv
tb/decode_unit_assert.sv
tb/decode_unit_tb.sv
